/* rtl/rtos_pkg.sv */
// rtos kernel widths, service opcodes, task state encoding, command argument union, lowest-id helper.
package rtos_pkg;

    localparam int num_tasks       = 8;
    localparam int tskid_width     = 3;
    localparam int num_sems        = 4;
    localparam int semid_width     = 2;
    localparam int sem_count_width = 4;   // count saturates at 15.
    localparam int flag_width      = 8;
    localparam int arg_width       = 24;

    // service call opcodes, anything else is a no-op.
    typedef enum logic [3:0] {
        op_act_tsk = 4'd1,
        op_ext_tsk = 4'd2,
        op_wai_sem = 4'd3,
        op_sig_sem = 4'd4,
        op_set_flg = 4'd5,
        op_clr_flg = 4'd6,
        op_wai_flg = 4'd7
    } rtos_op_e;

    typedef enum logic [1:0] {
        ts_idle    = 2'd0,
        ts_ready   = 2'd1,
        ts_wai_sem = 2'd2,
        ts_wai_flg = 2'd3
    } task_state_e;

    typedef struct packed {
        logic [arg_width-semid_width-1:0] rsvd;
        logic [semid_width-1:0]           semid;
    } sem_arg_t;

    typedef struct packed {
        logic [arg_width-flag_width-2:0] rsvd;
        logic                            mode;      // 0 any bit, 1 all bits.
        logic [flag_width-1:0]           pattern;
    } flg_arg_t;

    typedef union packed {
        sem_arg_t sem;
        flg_arg_t flg;
    } rtos_arg_u;

    // lowest set bit wins, so task 0 has the highest priority.
    function automatic logic [tskid_width-1:0] lowest_id(input logic [num_tasks-1:0] mask);
        logic [tskid_width-1:0] id;
        id = '0;
        for (int i = num_tasks - 1; i >= 0; i--) begin
            if (mask[i]) id = tskid_width'(i);
        end
        return id;
    endfunction

endpackage

/* rtl/rtos_cmd_if.sv */
// decoded service call interface with issuer, unit and dispatch modports.
`timescale 1ns/1ps

interface rtos_cmd_if;
    import rtos_pkg::*;

    logic                   valid;   // one cycle, the cycle before ack.
    rtos_op_e               op;
    logic [tskid_width-1:0] tskid;
    rtos_arg_u              arg;

    modport issuer (
        output valid,
        output op,
        output tskid,
        output arg
    );

    modport unit (
        input valid,
        input op,
        input tskid,
        input arg
    );

    modport dispatch (
        input valid,
        input op,
        input tskid,
        input arg
    );

endinterface

/* rtl/rtos_svc_wb.sv */
// wishbone classic slave: svc command decode, one-cycle ack, status register reads.
`timescale 1ns/1ps

module rtos_svc_wb #(
    parameter int num_tasks = rtos_pkg::num_tasks,
    parameter int num_sems  = rtos_pkg::num_sems
) (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic                                         wb_cyc,
    input  logic                                         wb_stb,
    input  logic                                         wb_we,
    input  logic [4:0]                                   wb_adr,
    input  logic [31:0]                                  wb_dat_w,
    output logic [31:0]                                  wb_dat_r,
    output logic                                         wb_ack,
    input  logic [2*num_tasks-1:0]                       state_vec,
    input  logic                                         run_valid,
    input  logic [rtos_pkg::tskid_width-1:0]             run_tskid,
    input  logic [rtos_pkg::flag_width-1:0]              flag,
    input  logic [num_sems*rtos_pkg::sem_count_width-1:0] sem_count,
    rtos_cmd_if.issuer                                   cmd
);
    import rtos_pkg::*;

    localparam logic [2:0] adr_svc   = 3'd0;
    localparam logic [2:0] adr_run   = 3'd1;
    localparam logic [2:0] adr_state = 3'd2;
    localparam logic [2:0] adr_flag  = 3'd3;

    logic        req;
    logic [2:0]  reg_sel;
    logic [31:0] rd_data;

    assign req     = wb_cyc && wb_stb && !wb_ack;   // new request, not yet acked.
    assign reg_sel = wb_adr[4:2];                   // word address.

    // command word split.
    assign cmd.valid = req && wb_we && (reg_sel == adr_svc);
    assign cmd.op    = rtos_op_e'(wb_dat_w[31:28]);
    assign cmd.tskid = wb_dat_w[24 +: tskid_width];
    assign cmd.arg   = rtos_arg_u'(wb_dat_w[arg_width-1:0]);

    always_comb begin
        rd_data = '0;
        case (reg_sel)
            adr_run:   rd_data = 32'({run_valid, run_tskid});
            adr_state: rd_data = 32'(state_vec);
            adr_flag:  rd_data = 32'(flag);
            default: begin
                // semaphore counts at 4..7, svc reads back 0.
                if (reg_sel[2] && (32'(reg_sel[1:0]) < num_sems)) begin
                    rd_data = 32'(sem_count[reg_sel[1:0]*sem_count_width +: sem_count_width]);
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req;   // exactly one cycle per request.
        end
    end

    // sampled before the command takes effect.
    always_ff @(posedge clk) begin
        if (req) begin
            wb_dat_r <= wb_we ? '0 : rd_data;
        end
    end

endmodule

/* rtl/rtos_semaphore.sv */
// counting semaphores with per-semaphore waiter sets and wake/block decision.
`timescale 1ns/1ps

module rtos_semaphore #(
    parameter int num_tasks = rtos_pkg::num_tasks,
    parameter int num_sems  = rtos_pkg::num_sems
) (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic [num_tasks-1:0]                         ready_mask,
    output logic [num_tasks-1:0]                         sem_wake,
    output logic                                         sem_block,
    output logic [num_sems*rtos_pkg::sem_count_width-1:0] sem_count,
    rtos_cmd_if.unit                                     cmd
);
    import rtos_pkg::*;

    localparam logic [sem_count_width-1:0] count_max = '1;

    logic [num_sems-1:0][sem_count_width-1:0] count;
    logic [num_sems-1:0][num_tasks-1:0]       waiters;
    logic [semid_width-1:0]                   semid;
    logic                                     sem_ok;
    logic                                     do_wai;
    logic                                     do_sig;
    logic                                     has_count;
    logic                                     has_waiter;
    logic [tskid_width-1:0]                   first_waiter;

    assign semid  = cmd.arg.sem.semid;
    assign sem_ok = 32'(semid) < num_sems;

    // wai_sem only counts for a ready caller.
    assign do_wai = cmd.valid && sem_ok && (cmd.op == op_wai_sem) && ready_mask[cmd.tskid];
    assign do_sig = cmd.valid && sem_ok && (cmd.op == op_sig_sem);

    assign has_count    = count[semid] != '0;
    assign has_waiter   = |waiters[semid];
    assign first_waiter = lowest_id(waiters[semid]);

    assign sem_block = do_wai && !has_count;
    assign sem_count = count;

    always_comb begin
        sem_wake = '0;
        if (do_sig && has_waiter) begin
            sem_wake[first_waiter] = 1'b1;   // highest priority waiter only.
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count   <= '0;
            waiters <= '0;
        end else if (do_wai) begin
            if (has_count) begin
                count[semid] <= count[semid] - 1'b1;
            end else begin
                waiters[semid][cmd.tskid] <= 1'b1;
            end
        end else if (do_sig) begin
            if (has_waiter) begin
                waiters[semid][first_waiter] <= 1'b0;   // count unchanged on handoff.
            end else if (count[semid] != count_max) begin
                count[semid] <= count[semid] + 1'b1;
            end
        end
    end

endmodule

/* rtl/rtos_eventflag.sv */
// event flag register, per-task wait pattern and mode, wake/block decision.
`timescale 1ns/1ps

module rtos_eventflag #(
    parameter int num_tasks = rtos_pkg::num_tasks
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [num_tasks-1:0]            ready_mask,
    output logic [num_tasks-1:0]            flg_wake,
    output logic                            flg_block,
    output logic [rtos_pkg::flag_width-1:0] flag,
    rtos_cmd_if.unit                        cmd
);
    import rtos_pkg::*;

    logic [num_tasks-1:0]                 waiting;
    logic [num_tasks-1:0]                 wait_mode;
    logic [num_tasks-1:0][flag_width-1:0] wait_pat;
    logic [flag_width-1:0]                pattern;
    logic [flag_width-1:0]                set_value;
    logic                                 do_set;
    logic                                 do_clr;
    logic                                 do_wai;

    // empty pattern never matches.
    function automatic logic flag_match(input logic [flag_width-1:0] value,
                                        input logic                  mode,
                                        input logic [flag_width-1:0] pat);
        if (pat == '0) return 1'b0;
        if (mode) return (value & pat) == pat;
        return (value & pat) != '0;
    endfunction

    assign pattern   = cmd.arg.flg.pattern;
    assign set_value = flag | pattern;

    assign do_set = cmd.valid && (cmd.op == op_set_flg);
    assign do_clr = cmd.valid && (cmd.op == op_clr_flg);
    assign do_wai = cmd.valid && (cmd.op == op_wai_flg) && ready_mask[cmd.tskid];

    assign flg_block = do_wai && !flag_match(flag, cmd.arg.flg.mode, pattern);

    // all waiters checked against the new flag at once.
    always_comb begin
        for (int i = 0; i < num_tasks; i++) begin
            flg_wake[i] = do_set && waiting[i] && flag_match(set_value, wait_mode[i], wait_pat[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            flag    <= '0;
            waiting <= '0;
        end else begin
            if (do_set) begin
                flag <= set_value;
            end else if (do_clr) begin
                flag <= flag & ~pattern;   // no wakeups on clear.
            end
            if (flg_block) begin
                waiting[cmd.tskid] <= 1'b1;
            end else begin
                waiting <= waiting & ~flg_wake;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (flg_block) begin
            wait_mode[cmd.tskid] <= cmd.arg.flg.mode;
            wait_pat[cmd.tskid]  <= pattern;
        end
    end

endmodule

/* rtl/rtos_task.sv */
// per-task state machine over idle, ready, semaphore wait and flag wait.
`timescale 1ns/1ps

module rtos_task #(
    parameter int tskid_width = rtos_pkg::tskid_width,
    parameter int tskid       = 0
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  activate,
    input  logic                  exit,
    input  logic                  block_sem,
    input  logic                  block_flg,
    input  logic                  wakeup,
    output rtos_pkg::task_state_e state
);
    import rtos_pkg::*;

    task_state_e next_state;
    logic        ev_act;
    logic        ev_ext;
    logic        ev_wake;

    // id must be reachable through the command tskid field.
    if (tskid >= (1 << tskid_width)) begin : g_id_check
        $error("task id %0d does not fit in %0d bits", tskid, tskid_width);
    end

    assign ev_act  = activate && (state == ts_idle);
    assign ev_ext  = exit && (state == ts_ready);
    assign ev_wake = wakeup && ((state == ts_wai_sem) || (state == ts_wai_flg));

    // events are one-hot, a single opcode per cycle.
    always_comb begin
        next_state = state;
        unique case (1'b1)
            ev_act:    next_state = ts_ready;
            ev_ext:    next_state = ts_idle;
            block_sem: next_state = ts_wai_sem;   // units only block ready tasks.
            block_flg: next_state = ts_wai_flg;
            ev_wake:   next_state = ts_ready;
            default:   next_state = state;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ts_idle;
        end else begin
            state <= next_state;
        end
    end

endmodule

/* rtl/rtos_dispatcher.sv */
// task state machines, event strobe decode and running task selection.
`timescale 1ns/1ps

module rtos_dispatcher #(
    parameter int num_tasks = rtos_pkg::num_tasks
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [num_tasks-1:0]             sem_wake,
    input  logic                             sem_block,
    input  logic [num_tasks-1:0]             flg_wake,
    input  logic                             flg_block,
    output logic [num_tasks-1:0]             ready_mask,
    output logic [2*num_tasks-1:0]           state_vec,
    output logic                             run_valid,
    output logic [rtos_pkg::tskid_width-1:0] run_tskid,
    rtos_cmd_if.dispatch                     cmd
);
    import rtos_pkg::*;

    logic [num_tasks-1:0] wake;
    logic                 is_act;
    logic                 is_ext;

    assign wake   = sem_wake | flg_wake;
    assign is_act = cmd.valid && (cmd.op == op_act_tsk);
    assign is_ext = cmd.valid && (cmd.op == op_ext_tsk);

    for (genvar i = 0; i < num_tasks; i++) begin : g_task
        task_state_e state;
        logic        sel;

        assign sel = cmd.tskid == tskid_width'(i);

        rtos_task #(
            .tskid_width (tskid_width),
            .tskid       (i)
        ) i_task (
            .clk       (clk),
            .reset     (reset),
            .activate  (is_act && sel),
            .exit      (is_ext && sel),
            .block_sem (sem_block && sel),
            .block_flg (flg_block && sel),
            .wakeup    (wake[i]),
            .state     (state)
        );

        assign ready_mask[i]       = state == ts_ready;
        assign state_vec[2*i +: 2] = state;
    end

    // one edge behind the task states.
    always_ff @(posedge clk) begin
        if (reset) begin
            run_valid <= 1'b0;
            run_tskid <= '0;
        end else begin
            run_valid <= |ready_mask;
            run_tskid <= lowest_id(ready_mask);
        end
    end

endmodule

/* rtl/rtos_core.sv */
// rtos kernel core top level: wishbone port, semaphore and flag units, dispatcher.
`timescale 1ns/1ps

module rtos_core #(
    parameter int num_tasks = rtos_pkg::num_tasks,
    parameter int num_sems  = rtos_pkg::num_sems
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             wb_cyc,
    input  logic                             wb_stb,
    input  logic                             wb_we,
    input  logic [4:0]                       wb_adr,
    input  logic [31:0]                      wb_dat_w,
    input  logic [3:0]                       wb_sel,      // full-word registers only.
    output logic [31:0]                      wb_dat_r,
    output logic                             wb_ack,
    output logic                             run_valid,
    output logic [rtos_pkg::tskid_width-1:0] run_tskid
);
    import rtos_pkg::*;

    logic [num_tasks-1:0]                ready_mask;
    logic [num_tasks-1:0]                sem_wake;
    logic [num_tasks-1:0]                flg_wake;
    logic                                sem_block;
    logic                                flg_block;
    logic [2*num_tasks-1:0]              state_vec;
    logic [flag_width-1:0]               flag;
    logic [num_sems*sem_count_width-1:0] sem_count;

    rtos_cmd_if cmd ();

    rtos_svc_wb #(
        .num_tasks (num_tasks),
        .num_sems  (num_sems)
    ) i_svc_wb (
        .clk       (clk),
        .reset     (reset),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .state_vec (state_vec),
        .run_valid (run_valid),
        .run_tskid (run_tskid),
        .flag      (flag),
        .sem_count (sem_count),
        .cmd       (cmd)
    );

    rtos_semaphore #(
        .num_tasks (num_tasks),
        .num_sems  (num_sems)
    ) i_semaphore (
        .clk        (clk),
        .reset      (reset),
        .ready_mask (ready_mask),
        .sem_wake   (sem_wake),
        .sem_block  (sem_block),
        .sem_count  (sem_count),
        .cmd        (cmd)
    );

    rtos_eventflag #(
        .num_tasks (num_tasks)
    ) i_eventflag (
        .clk        (clk),
        .reset      (reset),
        .ready_mask (ready_mask),
        .flg_wake   (flg_wake),
        .flg_block  (flg_block),
        .flag       (flag),
        .cmd        (cmd)
    );

    rtos_dispatcher #(
        .num_tasks (num_tasks)
    ) i_dispatcher (
        .clk        (clk),
        .reset      (reset),
        .sem_wake   (sem_wake),
        .sem_block  (sem_block),
        .flg_wake   (flg_wake),
        .flg_block  (flg_block),
        .ready_mask (ready_mask),
        .state_vec  (state_vec),
        .run_valid  (run_valid),
        .run_tskid  (run_tskid),
        .cmd        (cmd)
    );

endmodule

/* sim/rtos_assert.sv */
// bound checks: one-cycle wishbone ack, running task is ready, disjoint waiter sets.
`timescale 1ns/1ps

module rtos_assert #(
    parameter int num_tasks = rtos_pkg::num_tasks,
    parameter int num_sems  = rtos_pkg::num_sems
) (
    input logic                               clk,
    input logic                               reset,
    input logic                               wb_ack,
    input logic                               run_valid,
    input logic [rtos_pkg::tskid_width-1:0]   run_tskid,
    input logic [2*num_tasks-1:0]             state_vec,
    input logic [num_sems-1:0][num_tasks-1:0] sem_waiters,
    input logic [num_tasks-1:0]               flg_waiting
);
    import rtos_pkg::*;

    int                     fails = 0;
    logic [2*num_tasks-1:0] state_d;   // states the run register was built from.
    logic [num_tasks-1:0]   sem_any;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_d <= '0;
        end else begin
            state_d <= state_vec;
        end
    end

    always_comb begin
        sem_any = '0;
        for (int s = 0; s < num_sems; s++) sem_any = sem_any | sem_waiters[s];
    end

    ack_one_cycle: assert property (@(posedge clk) disable iff (reset) wb_ack |=> !wb_ack)
        else begin $error("wb_ack high for more than one cycle"); fails++; end

    run_is_ready: assert property (@(posedge clk) disable iff (reset)
        run_valid |-> state_d[2*run_tskid +: 2] == ts_ready)
        else begin $error("running task is not ready"); fails++; end

    waiters_disjoint: assert property (@(posedge clk) disable iff (reset)
        (sem_any & flg_waiting) == '0)
        else begin $error("task waits on a semaphore and the flag"); fails++; end

endmodule

/* sim/tb_rtos.sv */
// testbench for rtos_core with clock, reset, wishbone driver, reference model, compare tasks, random mix.
`timescale 1ns/1ps

module tb_rtos;
    import rtos_pkg::*;

    localparam logic [31:0] seed = 32'h8e4977df;

    logic        clk;
    logic        reset;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [4:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [3:0]  wb_sel;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic        run_valid;
    logic [tskid_width-1:0] run_tskid;

    // reference model of the kernel state.
    task_state_e                m_state   [num_tasks];
    logic [sem_count_width-1:0] m_count   [num_sems];
    logic [num_tasks-1:0]       m_waiters [num_sems];
    logic [flag_width-1:0]      m_flag;
    logic                       m_mode    [num_tasks];
    logic [flag_width-1:0]      m_pat     [num_tasks];

    rtos_core #(
        .num_tasks (num_tasks),
        .num_sems  (num_sems)
    ) i_dut (
        .clk       (clk),
        .reset     (reset),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_sel    (wb_sel),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .run_valid (run_valid),
        .run_tskid (run_tskid)
    );

    bind rtos_core rtos_assert #(
        .num_tasks (num_tasks),
        .num_sems  (num_sems)
    ) i_assert (
        .clk         (clk),
        .reset       (reset),
        .wb_ack      (wb_ack),
        .run_valid   (run_valid),
        .run_tskid   (run_tskid),
        .state_vec   (state_vec),
        .sem_waiters (i_semaphore.waiters),
        .flg_waiting (i_eventflag.waiting)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1, "stopping at first error");
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        m_flag = '0;
        for (int i = 0; i < num_tasks; i++) m_state[i] = ts_idle;
        for (int s = 0; s < num_sems; s++) begin
            m_count[s]   = '0;
            m_waiters[s] = '0;
        end
    endtask

    // one single transfer held until ack.
    task automatic wb_transfer(input logic we, input logic [4:0] adr, input logic [31:0] data,
                               output logic [31:0] rdata);
        int n;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = data;
        n = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
            if (!wb_ack && n >= 20) fail_run("wishbone ack never came within 20 cycles");
        end while (!wb_ack);
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [4:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        wb_transfer(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input logic [4:0] adr, output logic [31:0] data);
        wb_transfer(1'b0, adr, 32'h0, data);
    endtask

    function automatic logic flag_holds(input logic [flag_width-1:0] f, input logic all_mode,
                                        input logic [flag_width-1:0] p);
        logic hit;
        hit = all_mode ? ((f & p) == p) : ((f & p) != '0);
        return hit && (p != '0);   // empty pattern never holds.
    endfunction

    task automatic model_apply(input logic [31:0] word);
        logic [3:0]            op;
        int                    t;
        int                    s;
        logic [flag_width-1:0] p;
        logic                  mode;
        int                    first;
        op   = word[31:28];
        t    = word[26:24];
        s    = word[1:0];
        p    = word[7:0];
        mode = word[8];
        case (op)
            op_act_tsk: if (m_state[t] == ts_idle) m_state[t] = ts_ready;
            op_ext_tsk: if (m_state[t] == ts_ready) m_state[t] = ts_idle;
            op_wai_sem: begin
                if (m_state[t] == ts_ready) begin
                    if (m_count[s] != 0) begin
                        m_count[s] = m_count[s] - 1'b1;
                    end else begin
                        m_waiters[s][t] = 1'b1;
                        m_state[t]      = ts_wai_sem;
                    end
                end
            end
            op_sig_sem: begin
                first = -1;
                for (int i = num_tasks - 1; i >= 0; i--) if (m_waiters[s][i]) first = i;
                if (first >= 0) begin
                    m_waiters[s][first] = 1'b0;
                    m_state[first]      = ts_ready;
                end else if (m_count[s] < 15) begin
                    m_count[s] = m_count[s] + 1'b1;
                end
            end
            op_set_flg: begin
                m_flag = m_flag | p;
                for (int i = 0; i < num_tasks; i++) begin
                    if (m_state[i] == ts_wai_flg && flag_holds(m_flag, m_mode[i], m_pat[i]))
                        m_state[i] = ts_ready;
                end
            end
            op_clr_flg: m_flag = m_flag & ~p;
            op_wai_flg: begin
                if (m_state[t] == ts_ready && !flag_holds(m_flag, mode, p)) begin
                    m_mode[t]  = mode;
                    m_pat[t]   = p;
                    m_state[t] = ts_wai_flg;
                end
            end
            default: ;   // no-op opcode.
        endcase
    endtask

    task automatic check_state(input task_state_e got, input int id);
        if (got !== m_state[id])
            fail_run($sformatf("Error: state[%0d] got %h expected %h", id, got, m_state[id]));
    endtask

    task automatic check_run(input logic got_valid, input logic [tskid_width-1:0] got_id,
                             input string where);
        logic                   exp_valid;
        logic [tskid_width-1:0] exp_id;
        exp_valid = 1'b0;
        exp_id    = '0;
        for (int i = num_tasks - 1; i >= 0; i--) begin
            if (m_state[i] == ts_ready) begin
                exp_valid = 1'b1;
                exp_id    = tskid_width'(i);
            end
        end
        if (got_valid !== exp_valid)
            fail_run($sformatf("Error: run_valid (%s) got %h expected %h", where, got_valid,
                               exp_valid));
        if (exp_valid && got_id !== exp_id)
            fail_run($sformatf("Error: run_tskid (%s) got %h expected %h", where, got_id, exp_id));
    endtask

    task automatic check_flag(input logic [flag_width-1:0] got);
        if (got !== m_flag) fail_run($sformatf("Error: flag got %h expected %h", got, m_flag));
    endtask

    task automatic check_count(input logic [sem_count_width-1:0] got, input int s);
        if (got !== m_count[s])
            fail_run($sformatf("Error: sem_count[%0d] got %h expected %h", s, got, m_count[s]));
    endtask

    task automatic check_all();
        logic [31:0] d;
        wb_read(5'h08, d);
        for (int i = 0; i < num_tasks; i++) check_state(task_state_e'(d[2*i +: 2]), i);
        wb_read(5'h04, d);
        check_run(d[3], d[2:0], "run register");
        check_run(run_valid, run_tskid, "port");
        wb_read(5'h0c, d);
        check_flag(d[flag_width-1:0]);
        for (int s = 0; s < num_sems; s++) begin
            wb_read(5'(16 + 4 * s), d);
            check_count(d[sem_count_width-1:0], s);
        end
        if (i_dut.i_assert.fails != 0) fail_run("a bound assertion failed");
    endtask

    task automatic do_cmd(input logic [3:0] op, input int t, input logic [23:0] arg);
        logic [31:0] word;
        word = {op, 1'b0, 3'(t), arg};
        wb_write(5'h00, word);
        model_apply(word);
        check_all();
    endtask

    initial begin
        reset    = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        wb_sel   = 4'hf;
        void'($urandom(seed));
        apply_reset();
        check_all();

        for (int n = 0; n < 40; n++) begin
            do_cmd($urandom_range(0, 1) ? op_act_tsk : op_ext_tsk, $urandom_range(0, 7), '0);
        end

        // semaphores.
        apply_reset();
        for (int t = 0; t < num_tasks; t++) do_cmd(op_act_tsk, t, '0);
        do_cmd(op_wai_sem, 3, 24'd0);   // zero count blocks.
        do_cmd(op_wai_sem, 1, 24'd0);
        do_cmd(op_wai_sem, 3, 24'd0);   // not ready so no change.
        do_cmd(op_ext_tsk, 5, '0);
        do_cmd(op_wai_sem, 5, 24'd0);   // idle caller ignored.
        do_cmd(op_sig_sem, 0, 24'd0);   // task 1 first.
        do_cmd(op_sig_sem, 0, 24'd0);
        repeat (17) do_cmd(op_sig_sem, 0, 24'd2);
        do_cmd(op_wai_sem, 2, 24'd2);

        // event flag.
        apply_reset();
        for (int t = 0; t < num_tasks; t++) do_cmd(op_act_tsk, t, '0);
        do_cmd(op_set_flg, 0, 24'h00000f);
        do_cmd(op_clr_flg, 0, 24'h000003);
        do_cmd(op_wai_flg, 3, 24'h000006);   // any mode passes.
        do_cmd(op_wai_flg, 4, 24'h000030);   // any mode blocks.
        do_cmd(op_wai_flg, 5, 24'h00010c);   // all mode passes.
        do_cmd(op_wai_flg, 6, 24'h000174);   // all mode blocks.
        do_cmd(op_wai_flg, 2, 24'h000000);   // empty pattern in any mode.
        do_cmd(op_wai_flg, 7, 24'h000100);   // empty pattern in all mode.
        do_cmd(op_set_flg, 0, 24'h000070);   // wakes 4 and 6 together.
        do_cmd(op_set_flg, 0, 24'h0000ff);
        do_cmd(op_clr_flg, 0, 24'h0000aa);

        apply_reset();
        check_all();
        for (int n = 0; n < 2000; n++) begin
            if ($urandom_range(0, 15) == 0) begin
                wb_write(5'($urandom_range(1, 7) * 4), $urandom);   // read-only address ignored.
                check_all();
            end else begin
                do_cmd(4'($urandom_range(0, 8)), $urandom_range(0, 7), 24'($urandom));
            end
        end

        if (i_dut.i_assert.fails != 0) begin
            fail_run("a bound assertion failed");
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

/* verilog.f */
rtl/rtos_pkg.sv
rtl/rtos_cmd_if.sv
rtl/rtos_svc_wb.sv
rtl/rtos_semaphore.sv
rtl/rtos_eventflag.sv
rtl/rtos_task.sv
rtl/rtos_dispatcher.sv
rtl/rtos_core.sv
sim/rtos_assert.sv
sim/tb_rtos.sv

/* Bender.yml */
package:
  name: rtos_core

sources:
  - rtl/rtos_pkg.sv
  - rtl/rtos_cmd_if.sv
  - rtl/rtos_svc_wb.sv
  - rtl/rtos_semaphore.sv
  - rtl/rtos_eventflag.sv
  - rtl/rtos_task.sv
  - rtl/rtos_dispatcher.sv
  - rtl/rtos_core.sv
  - target: simulation
    files:
      - sim/rtos_assert.sv
      - sim/tb_rtos.sv
